// File: src/spi_pkg.sv
`default_nettype none

package spi_pkg;

    typedef logic [7:0]  addr_t;     // bus address
    typedef logic [7:0]  byte_t;     // bus data
    typedef logic [15:0] bit_cnt_t;  // frame length and bit counter
    typedef logic [31:0] word_t;     // wait length and repeat count
    typedef logic [6:0]  bit_idx_t;  // bit address into a pattern memory

    localparam int    MEM_BYTES = 16;
    localparam int    MEM_BITS  = 8 * MEM_BYTES;
    localparam byte_t VERSION   = 8'd2;

    // register map
    localparam addr_t REG_SOFT_RST    = 8'd0;
    localparam addr_t REG_START       = 8'd1;   // read returns done in bit 0
    localparam addr_t REG_BITS_LO     = 8'd3;   // 3..4
    localparam addr_t REG_WAIT_0      = 8'd5;   // 5..8
    localparam addr_t REG_REPEAT_0    = 8'd9;   // 9..12
    localparam addr_t REG_EXT_EN      = 8'd13;
    localparam addr_t REG_MEM_SIZE_LO = 8'd14;  // 14..15, read only

    localparam addr_t OUT_MEM_BASE = 8'd16;
    localparam addr_t IN_MEM_BASE  = 8'd32;

    localparam bit_cnt_t DEF_BITS   = 16'(MEM_BITS);
    localparam word_t    DEF_REPEAT = 32'd1;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_SHIFT,  // frame bits on the wire
        SEQ_WAIT,   // gap of wait_len cycles
        SEQ_GAP     // one cycle with counter at 0
    } seq_state_t;

endpackage

`default_nettype wire

// File: src/spi_if.sv
`timescale 1ns/10ps
`default_nettype none

interface spi_ctrl_if;
    import spi_pkg::*;

    bit_cnt_t bits;
    word_t    wait_len;
    word_t    repeat_cnt;   // 0 runs until soft reset
    logic     ext_en;
    logic     start;        // one-cycle pulse
    logic     soft_rst;     // one-cycle pulse
    logic     done;         // pulse back to the register bank

    modport regs (output bits, wait_len, repeat_cnt, ext_en, start, soft_rst,
                  input  done);
    modport seq  (input  bits, wait_len, repeat_cnt, ext_en, start, soft_rst,
                  output done);
endinterface

interface spi_frame_if;
    import spi_pkg::*;

    logic     active;   // high while a frame is shifting
    bit_idx_t bit_idx;  // counter minus 1

    modport seq   (output active, bit_idx);
    modport shift (input  active, bit_idx);
endinterface

interface spi_bit_if;
    import spi_pkg::*;

    bit_idx_t rd_idx;
    logic     out_bit;
    logic     wr_en;
    bit_idx_t wr_idx;
    logic     wr_bit;

    modport shift (output rd_idx, wr_en, wr_idx, wr_bit, input out_bit);
    modport mem   (input  rd_idx, wr_en, wr_idx, wr_bit, output out_bit);
endinterface

`default_nettype wire

// File: src/spi_regs.sv
`timescale 1ns/10ps
`default_nettype none

module spi_regs (
    input  logic           SPI_CLK,
    input  logic           RST,
    input  spi_pkg::addr_t bus_add,
    input  spi_pkg::byte_t bus_data_in,
    input  logic           bus_wr,
    output spi_pkg::byte_t bus_data_out,
    input  spi_pkg::byte_t mem_rd_data,
    spi_ctrl_if.regs       ctrl
);
    import spi_pkg::*;

    byte_t cfg [REG_START + 1 : REG_EXT_EN];  // writable registers 2..13
    addr_t prev_add;
    logic  done_flag;
    logic  wr_soft_rst;
    logic  wr_start;

    assign wr_soft_rst = bus_wr && (bus_add == REG_SOFT_RST);
    assign wr_start    = bus_wr && (bus_add == REG_START);

    always_ff @(posedge SPI_CLK) begin
        if (RST || wr_soft_rst) begin
            for (int i = REG_START + 1; i <= REG_EXT_EN; i++) begin
                cfg[i] <= '0;
            end
            for (int b = 0; b < 2; b++) begin
                cfg[REG_BITS_LO + b] <= DEF_BITS[8*b +: 8];
            end
            for (int b = 0; b < 4; b++) begin
                cfg[REG_REPEAT_0 + b] <= DEF_REPEAT[8*b +: 8];
            end
        end else if (bus_wr && (bus_add > REG_START) && (bus_add <= REG_EXT_EN)) begin
            cfg[bus_add[3:0]] <= bus_data_in;
        end
    end

    always_ff @(posedge SPI_CLK) begin
        if (RST || wr_soft_rst) begin
            done_flag <= 1'b1;                // idle reads as done
        end else if (wr_start) begin
            done_flag <= 1'b0;
        end else if (ctrl.done) begin
            done_flag <= 1'b1;
        end
    end

    // read data appears one cycle after the address
    always_ff @(posedge SPI_CLK) begin
        prev_add <= bus_add;
    end

    always_comb begin
        if (prev_add >= OUT_MEM_BASE) begin
            bus_data_out = mem_rd_data;       // both pattern memories
        end else if (prev_add == REG_SOFT_RST) begin
            bus_data_out = VERSION;
        end else if (prev_add == REG_START) begin
            bus_data_out = {7'b0, done_flag};
        end else if (prev_add == REG_MEM_SIZE_LO) begin
            bus_data_out = MEM_BYTES[7:0];
        end else if (prev_add == REG_MEM_SIZE_LO + 1) begin
            bus_data_out = MEM_BYTES[15:8];
        end else begin
            bus_data_out = cfg[prev_add[3:0]];
        end
    end

    assign ctrl.bits       = {cfg[REG_BITS_LO + 1], cfg[REG_BITS_LO]};
    assign ctrl.wait_len   = {cfg[REG_WAIT_0 + 3], cfg[REG_WAIT_0 + 2],
                              cfg[REG_WAIT_0 + 1], cfg[REG_WAIT_0]};
    assign ctrl.repeat_cnt = {cfg[REG_REPEAT_0 + 3], cfg[REG_REPEAT_0 + 2],
                              cfg[REG_REPEAT_0 + 1], cfg[REG_REPEAT_0]};
    assign ctrl.ext_en     = cfg[REG_EXT_EN][0];
    assign ctrl.start      = wr_start;
    assign ctrl.soft_rst   = wr_soft_rst;

endmodule

`default_nettype wire

// File: src/spi_bit_mem.sv
`timescale 1ns/10ps
`default_nettype none

module spi_bit_mem (
    input  logic           SPI_CLK,
    input  spi_pkg::addr_t bus_add,
    input  spi_pkg::byte_t bus_data_in,
    input  logic           bus_wr,
    output spi_pkg::byte_t rd_data,
    spi_bit_if.mem         bits
);
    import spi_pkg::*;

    logic [MEM_BITS-1:0] out_mem;  // pattern, bit 0 goes out first
    logic [MEM_BITS-1:0] in_mem;   // captured sdo bits
    logic                out_win;
    logic                in_win;
    bit_idx_t            out_base;
    bit_idx_t            in_base;
    byte_t               rd_next;

    assign out_win = (bus_add >= OUT_MEM_BASE) && (bus_add < OUT_MEM_BASE + MEM_BYTES);
    assign in_win  = (bus_add >= IN_MEM_BASE) && (bus_add < IN_MEM_BASE + MEM_BYTES);

    // first bit address of the addressed byte
    assign out_base = bit_idx_t'({bus_add - OUT_MEM_BASE, 3'b000});
    assign in_base  = bit_idx_t'({bus_add - IN_MEM_BASE, 3'b000});

    always_ff @(posedge SPI_CLK) begin
        if (bus_wr && out_win) begin
            for (int i = 0; i < 8; i++) begin
                out_mem[out_base + bit_idx_t'(i)] <= bus_data_in[7 - i];  // msb first
            end
        end
    end

    always_ff @(posedge SPI_CLK) begin
        if (bits.wr_en) begin
            in_mem[bits.wr_idx] <= bits.wr_bit;
        end
    end

    always_comb begin
        rd_next = '0;
        for (int i = 0; i < 8; i++) begin
            if (out_win) begin
                rd_next[7 - i] = out_mem[out_base + bit_idx_t'(i)];
            end else if (in_win) begin
                rd_next[7 - i] = in_mem[in_base + bit_idx_t'(i)];
            end
        end
    end

    always_ff @(posedge SPI_CLK) begin
        rd_data <= rd_next;
    end

    assign bits.out_bit = out_mem[bits.rd_idx];  // combinational bit read

endmodule

`default_nettype wire

// File: src/spi_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module spi_sequencer (
    input  logic      SPI_CLK,
    input  logic      RST,
    input  logic      ext_start,
    spi_ctrl_if.seq   ctrl,
    spi_frame_if.seq  frame
);
    import spi_pkg::*;

    seq_state_t state;
    bit_cnt_t   bit_cnt;
    word_t      wait_cnt;
    word_t      rep_cnt;       // number of the running frame
    logic [2:0] ext_ff;
    logic       ext_rise;
    logic       go;
    logic       last_bit;
    logic       wait_over;
    logic       final_frame;

    // ext_start is asynchronous to SPI_CLK
    always_ff @(posedge SPI_CLK) begin
        if (RST) begin
            ext_ff <= '0;
        end else begin
            ext_ff <= {ext_ff[1:0], ext_start};
        end
    end

    assign ext_rise    = ext_ff[1] & ~ext_ff[2];
    assign go          = ctrl.start | (ext_rise & ctrl.ext_en);
    assign last_bit    = bit_cnt >= ctrl.bits;
    assign wait_over   = wait_cnt >= ctrl.wait_len;
    assign final_frame = (ctrl.repeat_cnt != '0) && (rep_cnt >= ctrl.repeat_cnt);

    always_ff @(posedge SPI_CLK) begin
        if (RST || ctrl.soft_rst) begin
            state    <= SEQ_IDLE;
            bit_cnt  <= '0;
            wait_cnt <= '0;
            rep_cnt  <= '0;
        end else if (go) begin                // also restarts a running sequence
            state    <= SEQ_SHIFT;
            bit_cnt  <= 16'd1;
            wait_cnt <= '0;
            rep_cnt  <= 32'd1;
        end else begin
            case (state)
                SEQ_SHIFT: begin
                    if (!last_bit) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end else if (ctrl.wait_len == '0) begin
                        state   <= SEQ_GAP;
                        bit_cnt <= '0;
                    end else begin
                        state    <= SEQ_WAIT;
                        bit_cnt  <= bit_cnt + 1'b1;
                        wait_cnt <= 32'd1;
                    end
                end
                SEQ_WAIT: begin
                    if (wait_over) begin
                        state   <= SEQ_GAP;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt  <= bit_cnt + 1'b1;
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                SEQ_GAP: begin
                    if (final_frame) begin
                        state <= SEQ_IDLE;
                    end else begin
                        state   <= SEQ_SHIFT;     // next repeat
                        bit_cnt <= 16'd1;
                        rep_cnt <= rep_cnt + 1'b1;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    assign frame.active  = (state == SEQ_SHIFT) && (bit_cnt <= ctrl.bits);
    assign frame.bit_idx = bit_idx_t'(bit_cnt - 1'b1);  // wraps at MEM_BITS
    assign ctrl.done     = (state == SEQ_GAP) && final_frame;

endmodule

`default_nettype wire

// File: src/spi_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module spi_shifter (
    input  logic       SPI_CLK,
    input  logic       RST,
    spi_frame_if.shift frame,
    spi_bit_if.shift   bits,
    input  logic       sdo,
    output logic       sdi,
    output logic       sclk,
    output logic       sen,
    output logic       sld
);
    import spi_pkg::*;

    bit_idx_t   launch_idx;  // index of the bit now on sdi
    logic [1:0] sen_hist;

    assign bits.rd_idx = frame.bit_idx;

    // launch on the falling edge, half a cycle ahead of sclk rising
    always_ff @(negedge SPI_CLK) begin
        if (RST) begin
            sen <= 1'b0;
            sdi <= 1'b0;
        end else begin
            sen <= frame.active;
            sdi <= bits.out_bit & frame.active;
        end
    end

    always_ff @(negedge SPI_CLK) begin
        launch_idx <= frame.bit_idx;
    end

    assign sclk = SPI_CLK & sen;  // sen only moves while SPI_CLK is low

    // sdo lands in the same bit index as the sdi it answers
    assign bits.wr_en  = sen;
    assign bits.wr_idx = launch_idx;
    assign bits.wr_bit = sdo;

    always_ff @(posedge SPI_CLK) begin
        if (RST) begin
            sen_hist <= '0;
            sld      <= 1'b0;
        end else begin
            sen_hist <= {sen_hist[0], sen};
            sld      <= sen_hist[1] & ~sen_hist[0];  // load after the frame ends
        end
    end

endmodule

`default_nettype wire

// File: src/spi_core.sv
`timescale 1ns/10ps
`default_nettype none

module spi_core (
    input  logic           SPI_CLK,
    input  logic           RST,
    input  spi_pkg::addr_t bus_add,
    input  spi_pkg::byte_t bus_data_in,
    input  logic           bus_wr,
    input  logic           bus_rd,        // read strobe, reads need none
    output spi_pkg::byte_t bus_data_out,
    input  logic           ext_start,
    input  logic           sdo,
    output logic           sdi,
    output logic           sclk,
    output logic           sen,
    output logic           sld
);
    import spi_pkg::*;

    byte_t mem_rd_data;

    spi_ctrl_if  ctrl_if ();
    spi_frame_if frame_if ();
    spi_bit_if   bit_if ();

    spi_regs i_spi_regs (
        .SPI_CLK      (SPI_CLK),
        .RST          (RST),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_data_out (bus_data_out),
        .mem_rd_data  (mem_rd_data),
        .ctrl         (ctrl_if.regs)
    );

    spi_bit_mem i_spi_bit_mem (
        .SPI_CLK     (SPI_CLK),
        .bus_add     (bus_add),
        .bus_data_in (bus_data_in),
        .bus_wr      (bus_wr),
        .rd_data     (mem_rd_data),
        .bits        (bit_if.mem)
    );

    spi_sequencer i_spi_sequencer (
        .SPI_CLK   (SPI_CLK),
        .RST       (RST),
        .ext_start (ext_start),
        .ctrl      (ctrl_if.seq),
        .frame     (frame_if.seq)
    );

    spi_shifter i_spi_shifter (
        .SPI_CLK (SPI_CLK),
        .RST     (RST),
        .frame   (frame_if.shift),
        .bits    (bit_if.shift),
        .sdo     (sdo),
        .sdi     (sdi),
        .sclk    (sclk),
        .sen     (sen),
        .sld     (sld)
    );

endmodule

`default_nettype wire

// File: testbench/spi_core_checker.sv
`timescale 1ns/10ps
`default_nettype none

module spi_core_checker (
    input logic SPI_CLK,
    input logic RST,
    input logic sen,
    input logic sclk,
    input logic sld,
    input logic active,
    input logic done
);

    // gated clock stays quiet outside a frame
    sclk_gated: assert property (@(posedge sclk) disable iff (RST) sen)
        else $error("sclk rose while sen was low");

    sld_single: assert property (@(posedge SPI_CLK) disable iff (RST) sld |=> !sld)
        else $error("sld longer than one cycle");

    done_apart: assert property (@(posedge SPI_CLK) disable iff (RST)
                                 !(done && (active || sen)))
        else $error("done pulse during an active frame");

endmodule

bind spi_core spi_core_checker i_spi_core_checker (
    .SPI_CLK (SPI_CLK),
    .RST     (RST),
    .sen     (sen),
    .sclk    (sclk),
    .sld     (sld),
    .active  (frame_if.active),
    .done    (ctrl_if.done)
);

`default_nettype wire

// File: testbench/tb_spi_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_spi_core;
    import spi_pkg::*;

    logic   SPI_CLK;
    logic   RST;
    addr_t  bus_add;
    byte_t  bus_data_in;
    logic   bus_wr;
    logic   bus_rd;
    byte_t  bus_data_out;
    logic   ext_start;
    logic   sdo;
    logic   sdi;
    logic   sclk;
    logic   sen;
    logic   sld;

    integer seed = 32'h1a75;
    int     errors = 0;
    int     checks = 0;
    int     sen_cnt = 0;
    int     sld_cnt = 0;
    byte_t  pat [MEM_BYTES];    // model copy of the output pattern
    logic   rec [$];            // sdi seen at each sclk rise

    spi_core i_spi_core (.*);

    initial SPI_CLK = 1'b0;
    always #10 SPI_CLK = ~SPI_CLK;

    always @(sdi) sdo = ~sdi;   // loopback slave answers with the inverse
    always @(posedge sclk) rec.push_back(sdi);
    always @(posedge sen) sen_cnt++;
    always @(negedge SPI_CLK) begin
        if (sld) begin
            sld_cnt++;
        end
    end

    task automatic tick();
        @(posedge SPI_CLK);
        #2;
    endtask

    task automatic write_reg(input addr_t a, input byte_t d);
        bus_add     = a;
        bus_data_in = d;
        bus_wr      = 1'b1;
        tick();
        bus_wr      = 1'b0;
    endtask

    task automatic read_reg(input addr_t a, output byte_t d);
        bus_add = a;
        tick();                 // data follows the address by one cycle
        d = bus_data_out;
    endtask

    task automatic report_mismatch(input string name, input int exp, input int act);
        $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
        errors++;
    endtask

    task automatic expect_reg(input string name, input addr_t a, input byte_t exp);
        byte_t d;
        read_reg(a, d);
        checks++;
        if (d !== exp) begin
            report_mismatch(name, exp, d);
        end
    endtask

    // pattern bit n, byte k bit 7 goes out first
    function automatic logic pattern_bit(input int n);
        int k;
        k = n % MEM_BITS;
        return pat[k / 8][7 - (k % 8)];
    endfunction

    task automatic check_defaults(input string name);
        expect_reg({name, " version"}, REG_SOFT_RST, VERSION);
        expect_reg({name, " bits lo"}, REG_BITS_LO, DEF_BITS[7:0]);
        expect_reg({name, " bits hi"}, addr_t'(REG_BITS_LO + 1), DEF_BITS[15:8]);
        expect_reg({name, " repeat"}, REG_REPEAT_0, DEF_REPEAT[7:0]);
        expect_reg({name, " mem size"}, REG_MEM_SIZE_LO, byte_t'(MEM_BYTES));
        expect_reg({name, " done"}, REG_START, 8'h01);
    endtask

    task automatic prepare(input int nbits);
        write_reg(REG_SOFT_RST, 8'h00);
        for (int k = 0; k < MEM_BYTES; k++) begin
            pat[k] = byte_t'($random(seed));
            write_reg(addr_t'(OUT_MEM_BASE + k), pat[k]);
        end
        write_reg(REG_BITS_LO, nbits[7:0]);
        write_reg(addr_t'(REG_BITS_LO + 1), nbits[15:8]);
        rec.delete();
        sen_cnt = 0;
        sld_cnt = 0;
    endtask

    task automatic wait_done();
        byte_t d;
        int    n;
        d = 8'h00;
        n = 0;
        while (d[0] !== 1'b1 && n < 2000) begin
            read_reg(REG_START, d);
            n++;
        end
        if (d[0] !== 1'b1) begin
            $display("timeout: done flag was not set after the sequence");
            errors++;
        end
    endtask

    task automatic wait_sld(input int count);
        int n;
        n = 0;
        while (sld_cnt < count && n < 1000) begin
            tick();
            n++;
        end
        if (sld_cnt < count) begin
            $display("timeout: only %0d of %0d sld pulses seen", sld_cnt, count);
            errors++;
        end
    endtask

    task automatic wait_sen(input logic level, input int limit);
        int n;
        n = 0;
        while (sen !== level && n < limit) begin
            tick();
            n++;
        end
        if (sen !== level) begin
            $display("timeout: sen did not reach %0b within %0d cycles", level, limit);
            errors++;
        end
    endtask

    task automatic check_frames(input string name, input int nbits, input int reps);
        checks += 3;
        if (rec.size() != nbits * reps) begin
            report_mismatch({name, " sclk pulses"}, nbits * reps, rec.size());
        end
        if (sen_cnt != reps) begin
            report_mismatch({name, " sen periods"}, reps, sen_cnt);
        end
        if (sld_cnt != reps) begin
            report_mismatch({name, " sld pulses"}, reps, sld_cnt);
        end
        for (int i = 0; i < rec.size() && i < nbits * reps; i++) begin
            checks++;
            if (rec[i] !== pattern_bit(i % nbits)) begin  // every frame restarts at bit 0
                report_mismatch($sformatf("%s bit %0d", name, i), pattern_bit(i % nbits),
                                rec[i]);
            end
        end
    endtask

    initial begin
        byte_t shadow [2:13];
        int    nbits;
        int    reps;
        int    gap;

        RST         = 1'b1;
        bus_add     = '0;
        bus_data_in = '0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        ext_start   = 1'b0;
        sdo         = 1'b1;
        repeat (2) @(posedge SPI_CLK);
        #2;
        RST = 1'b0;

        check_defaults("reset");
        for (int a = 2; a <= 13; a++) begin
            shadow[a] = byte_t'($random(seed));
            write_reg(addr_t'(a), shadow[a]);
        end
        for (int a = 2; a <= 13; a++) begin
            expect_reg($sformatf("readback %0d", a), addr_t'(a), shadow[a]);
        end

        for (int t = 0; t < 4; t++) begin
            nbits = 1 + ({$random(seed)} % 200);
            prepare(nbits);
            write_reg(REG_START, 8'h00);
            wait_done();
            wait_sld(1);
            check_frames("pattern", nbits, 1);
        end

        for (int t = 0; t < 3; t++) begin
            nbits = 1 + ({$random(seed)} % 40);
            reps  = 1 + ({$random(seed)} % 4);
            gap   = {$random(seed)} % 21;
            prepare(nbits);
            write_reg(REG_WAIT_0, byte_t'(gap));
            write_reg(REG_REPEAT_0, byte_t'(reps));
            write_reg(REG_START, 8'h00);
            wait_done();
            wait_sld(reps);
            check_frames("repeat", nbits, reps);
        end

        prepare(MEM_BITS);
        write_reg(REG_START, 8'h00);
        wait_done();
        wait_sld(1);
        for (int k = 0; k < MEM_BYTES; k++) begin
            expect_reg($sformatf("loopback %0d", k), addr_t'(IN_MEM_BASE + k), ~pat[k]);
        end

        prepare(16);
        ext_start = 1'b1;       // ext_en still 0 after soft reset
        tick();
        tick();
        ext_start = 1'b0;
        for (int n = 0; n < 20; n++) begin
            tick();
        end
        checks++;
        if (sen_cnt != 0) begin
            report_mismatch("ext start disabled", 0, sen_cnt);
        end
        write_reg(REG_EXT_EN, 8'h01);
        ext_start = 1'b1;
        tick();
        tick();
        ext_start = 1'b0;
        wait_sld(1);
        check_frames("ext start", 16, 1);

        prepare(200);
        write_reg(REG_START, 8'h00);
        wait_sen(1'b1, 100);
        write_reg(REG_SOFT_RST, 8'h00);  // abort in the middle of the frame
        wait_sen(1'b0, 4);                // far shorter than the 200 bit frame
        check_defaults("soft reset");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
src/spi_pkg.sv
src/spi_if.sv
src/spi_regs.sv
src/spi_bit_mem.sv
src/spi_sequencer.sv
src/spi_shifter.sv
src/spi_core.sv
testbench/spi_core_checker.sv
testbench/tb_spi_core.sv

// File: Makefile
TOP = tb_spi_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir sim.log
